// ==== logic/gx_video_pkg.sv ====
`default_nettype none

package gx_video_pkg;

    // ASIC RAM is 16K by 8
    localparam int ASIC_RAM_AW = 14;

    // Address bits above sprite id and row
    localparam int SPRITE_BASE_W = ASIC_RAM_AW - 8;

    // CRTC addresses in the top 1K window are sprite cells
    localparam logic [3:0] SPRITE_MA_TAG = 4'hF;

    // Sprite palettes start at 0x1000
    localparam logic [SPRITE_BASE_W-1:0] SPRITE_RAM_BASE = 6'h10;

    // Gate Array colour, two bits per channel
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb2_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

    // One character clock from CRTC and Gate Array
    typedef struct packed {
        logic [ASIC_RAM_AW-1:0] crtc_ma;
        logic [4:0]             crtc_ra;
        logic                   crtc_de;
        rgb2_t                  ga_rgb;
    } crtc_pixel_t;

    typedef struct packed {
        logic       active;
        logic [3:0] id;
    } sprite_hit_t;

endpackage

`default_nettype wire

// ==== logic/gx_regs_pkg.sv ====
`default_nettype none

package gx_regs_pkg;

    // Mode registers sit at even addresses in this page
    localparam logic [7:0] REG_PAGE = 8'hBC;

    // Register select from cpu_addr[2:1]
    localparam logic [1:0] REG_CONFIG = 2'd0;
    localparam logic [1:0] REG_MRER   = 2'd1;
    localparam logic [1:0] REG_ASIC   = 2'd2;

    // MRER value that mixes in the previous pixel
    localparam logic [4:0] MRER_AVERAGE = 5'h01;

    typedef enum logic [7:0] {
        ASIC_PALETTE    = 8'h02,
        ASIC_SPRITE_PRI = 8'h62,
        ASIC_BLEND      = 8'h82
    } asic_mode_e;

    // How the output pixel is formed
    typedef enum logic [2:0] {
        MIX_GATE        = 3'd0,
        MIX_PALETTE     = 3'd1,
        MIX_PAL_AVERAGE = 3'd2,
        MIX_SPRITE_PRI  = 3'd3,
        MIX_BLEND       = 3'd4
    } mix_mode_e;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;
    } cpu_bus_t;

endpackage

`default_nettype wire

// ==== logic/plus_mode_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module plus_mode_regs
    import gx_regs_pkg::*;
(
    input  logic      clk_sys,
    input  logic      reset,
    input  logic      plus_mode,
    input  cpu_bus_t  cpu,
    output mix_mode_e mix_mode
);

    logic [7:0] config_mode;
    logic [4:0] mrer_mode;
    asic_mode_e asic_mode;
    logic       asic_enabled;
    logic       reg_wr;
    logic [1:0] reg_sel;
    logic       opcode_known;

    // Even addresses in the register page only
    assign reg_wr  = cpu.wr && (cpu.addr[15:8] == REG_PAGE) && !cpu.addr[0];
    assign reg_sel = cpu.addr[2:1];

    assign opcode_known = (cpu.data == ASIC_PALETTE) ||
                          (cpu.data == ASIC_SPRITE_PRI) ||
                          (cpu.data == ASIC_BLEND);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            config_mode  <= '0;
            mrer_mode    <= '0;
            asic_mode    <= asic_mode_e'(8'h00);
            asic_enabled <= 1'b0;
        end else if (reg_wr) begin
            case (reg_sel)
                REG_CONFIG: config_mode <= cpu.data;
                REG_MRER:   mrer_mode <= cpu.data[4:0];
                REG_ASIC: begin
                    asic_mode <= asic_mode_e'(cpu.data);
                    // ASIC only takes over on a Plus machine
                    asic_enabled <= opcode_known && plus_mode;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        mix_mode = MIX_GATE;
        if ((config_mode != 8'h00) && plus_mode && asic_enabled) begin
            case (asic_mode)
                ASIC_PALETTE: begin
                    if (mrer_mode == MRER_AVERAGE) begin
                        mix_mode = MIX_PAL_AVERAGE;
                    end else begin
                        mix_mode = MIX_PALETTE;
                    end
                end
                ASIC_SPRITE_PRI: mix_mode = MIX_SPRITE_PRI;
                ASIC_BLEND:      mix_mode = MIX_BLEND;
                default:         mix_mode = MIX_GATE;
            endcase
        end
    end

    // An enabled ASIC always holds a known opcode
    a_enabled_not_gate: assert property (@(posedge clk_sys) disable iff (reset)
        (asic_enabled && plus_mode && (config_mode != 8'h00)) |-> (mix_mode != MIX_GATE));

endmodule

`default_nettype wire

// ==== logic/sprite_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_detect
    import gx_video_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        crtc_clken,
    input  crtc_pixel_t pixel,
    output sprite_hit_t hit_now,
    output sprite_hit_t hit_q
);

    logic tag_match;
    logic is_sprite;

    // Top four address bits mark the sprite window
    assign tag_match = (pixel.crtc_ma[13:10] == SPRITE_MA_TAG);
    assign is_sprite = pixel.crtc_de && tag_match;

    always_comb begin
        hit_now.active = is_sprite;
        // Id only meaningful on a hit, keep it quiet otherwise
        if (is_sprite) begin
            hit_now.id = pixel.crtc_ma[9:6];
        end else begin
            hit_now.id = 4'h0;
        end
    end

    // Stage 1 copy, aligned with the palette latch
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hit_q <= '0;
        end else if (crtc_clken) begin
            hit_q <= hit_now;
        end
    end

endmodule

`default_nettype wire

// ==== logic/palette_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module palette_fetch
    import gx_video_pkg::*;
    import gx_regs_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   crtc_clken,
    input  crtc_pixel_t            pixel,
    input  mix_mode_e              mix_mode,
    input  sprite_hit_t            sprite,
    output logic [ASIC_RAM_AW-1:0] asic_ram_addr,
    output logic                   asic_ram_rd,
    input  logic [7:0]             asic_ram_q,
    output rgb4_t                  palette,
    output rgb2_t                  ga_rgb_q,
    output rgb2_t                  prev_ga_rgb,
    output logic                   de_q
);

    rgb4_t ram_colour;

    // Read only for displayed pixels once the ASIC owns the video
    assign asic_ram_rd = crtc_clken && pixel.crtc_de && (mix_mode != MIX_GATE);

    always_comb begin
        if (!asic_ram_rd) begin
            asic_ram_addr = pixel.crtc_ma;
        end else if (sprite.active) begin
            // Sprite page, 16 rows per sprite
            asic_ram_addr = {SPRITE_RAM_BASE, sprite.id, pixel.crtc_ra[3:0]};
        end else begin
            asic_ram_addr = ASIC_RAM_AW'({pixel.crtc_ra[2:0], pixel.crtc_ma[1:0]});
        end
    end

    // RAM byte layout is xxBBGGRR
    always_comb begin
        ram_colour.r = {2'b00, asic_ram_q[1:0]};
        ram_colour.g = {2'b00, asic_ram_q[3:2]};
        ram_colour.b = {2'b00, asic_ram_q[5:4]};
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            palette     <= '0;
            ga_rgb_q    <= '0;
            prev_ga_rgb <= '0;
            de_q        <= 1'b0;
        end else if (crtc_clken) begin
            de_q <= pixel.crtc_de;
            // Blanked pixels leave colour history alone
            if (pixel.crtc_de) begin
                palette     <= ram_colour;
                prev_ga_rgb <= ga_rgb_q;
                ga_rgb_q    <= pixel.ga_rgb;
            end
        end
    end

    // Sprite hit must belong to the pixel being fetched
    a_sprite_is_current: assert property (@(posedge clk_sys) disable iff (reset)
        sprite.active |-> (pixel.crtc_de && (pixel.crtc_ma[13:10] == SPRITE_MA_TAG)));

endmodule

`default_nettype wire

// ==== logic/colour_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module colour_mixer
    import gx_video_pkg::*;
    import gx_regs_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        crtc_clken,
    input  mix_mode_e   mix_mode,
    input  rgb4_t       palette,
    input  rgb2_t       ga_rgb,
    input  rgb2_t       prev_ga_rgb,
    input  logic        de,
    input  sprite_hit_t sprite,
    output rgb4_t       rgb,
    output sprite_hit_t sprite_out
);

    mix_mode_e mode_q;
    rgb4_t     mixed;

    // Gate Array colour into the 4-bit range
    function automatic rgb4_t widen(input rgb2_t c);
        rgb4_t w;
        w.r = {2'b00, c.r};
        w.g = {2'b00, c.g};
        w.b = {2'b00, c.b};
        return w;
    endfunction

    function automatic logic [3:0] half_sum(input logic [3:0] a, input logic [3:0] b);
        logic [4:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[4:1];
    endfunction

    // Per channel mean of two colours
    function automatic rgb4_t blend(input rgb4_t a, input rgb4_t b);
        rgb4_t m;
        m.r = half_sum(a.r, b.r);
        m.g = half_sum(a.g, b.g);
        m.b = half_sum(a.b, b.b);
        return m;
    endfunction

    always_comb begin
        case (mode_q)
            MIX_GATE:        mixed = widen(ga_rgb);
            MIX_PALETTE:     mixed = palette;
            MIX_PAL_AVERAGE: mixed = blend(palette, widen(prev_ga_rgb));
            // Sprite wins, background shows through elsewhere
            MIX_SPRITE_PRI:  mixed = sprite.active ? palette : widen(ga_rgb);
            MIX_BLEND:       mixed = blend(palette, widen(ga_rgb));
            default:         mixed = widen(ga_rgb);
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mode_q     <= MIX_GATE;
            rgb        <= '0;
            sprite_out <= '0;
        end else if (crtc_clken) begin
            // Mode that fetched the pixel now in stage 1
            mode_q <= mix_mode;
            if (de) begin
                rgb        <= mixed;
                sprite_out <= sprite;
            end else begin
                rgb        <= '0;
                sprite_out <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/gx4000_video.sv ====
`timescale 1ns/1ps
`default_nettype none

module gx4000_video
    import gx_video_pkg::*;
    import gx_regs_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   plus_mode,
    input  logic                   crtc_clken,
    input  logic [ASIC_RAM_AW-1:0] crtc_ma,
    input  logic [4:0]             crtc_ra,
    input  logic                   crtc_de,
    input  logic [15:0]            cpu_addr,
    input  logic [7:0]             cpu_data,
    input  logic                   cpu_wr,
    input  logic [1:0]             r_in,
    input  logic [1:0]             g_in,
    input  logic [1:0]             b_in,
    output logic [3:0]             r_out,
    output logic [3:0]             g_out,
    output logic [3:0]             b_out,
    output logic                   sprite_active_out,
    output logic [3:0]             sprite_id_out,
    output logic [ASIC_RAM_AW-1:0] asic_ram_addr,
    output logic                   asic_ram_rd,
    input  logic [7:0]             asic_ram_q
);

    crtc_pixel_t pixel;
    cpu_bus_t    cpu;
    mix_mode_e   mix_mode;
    sprite_hit_t hit_now;
    sprite_hit_t hit_q;
    sprite_hit_t sprite_out;
    rgb4_t       palette;
    rgb4_t       rgb;
    rgb2_t       ga_rgb_q;
    rgb2_t       prev_ga_rgb;
    logic        de_q;

    assign pixel.crtc_ma  = crtc_ma;
    assign pixel.crtc_ra  = crtc_ra;
    assign pixel.crtc_de  = crtc_de;
    assign pixel.ga_rgb.r = r_in;
    assign pixel.ga_rgb.g = g_in;
    assign pixel.ga_rgb.b = b_in;

    assign cpu.addr = cpu_addr;
    assign cpu.data = cpu_data;
    assign cpu.wr   = cpu_wr;

    plus_mode_regs plus_mode_regs_inst (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .plus_mode (plus_mode),
        .cpu       (cpu),
        .mix_mode  (mix_mode)
    );

    sprite_detect sprite_detect_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .crtc_clken (crtc_clken),
        .pixel      (pixel),
        .hit_now    (hit_now),
        .hit_q      (hit_q)
    );

    // Stage 1, palette fetch from ASIC RAM
    palette_fetch palette_fetch_inst (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .crtc_clken    (crtc_clken),
        .pixel         (pixel),
        .mix_mode      (mix_mode),
        .sprite        (hit_now),
        .asic_ram_addr (asic_ram_addr),
        .asic_ram_rd   (asic_ram_rd),
        .asic_ram_q    (asic_ram_q),
        .palette       (palette),
        .ga_rgb_q      (ga_rgb_q),
        .prev_ga_rgb   (prev_ga_rgb),
        .de_q          (de_q)
    );

    // Stage 2, output pixel
    colour_mixer colour_mixer_inst (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .crtc_clken  (crtc_clken),
        .mix_mode    (mix_mode),
        .palette     (palette),
        .ga_rgb      (ga_rgb_q),
        .prev_ga_rgb (prev_ga_rgb),
        .de          (de_q),
        .sprite      (hit_q),
        .rgb         (rgb),
        .sprite_out  (sprite_out)
    );

    assign r_out             = rgb.r;
    assign g_out             = rgb.g;
    assign b_out             = rgb.b;
    assign sprite_active_out = sprite_out.active;
    assign sprite_id_out     = sprite_out.id;

endmodule

`default_nettype wire

// ==== verification/tb_gx4000_video.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gx4000_video
    import gx_video_pkg::*;
();

    localparam string VECTOR_FILE = "verification/golden_vectors_video.txt";
    localparam int HALF_PERIOD = 50;

    // One line of the vector file, either a CPU write or a pixel
    typedef struct packed {
        logic                   is_write;
        logic [15:0]            addr;
        logic [7:0]             data;
        logic                   plus;
        logic [ASIC_RAM_AW-1:0] ma;
        logic [4:0]             ra;
        logic                   de;
        rgb2_t                  ga;
        rgb4_t                  exp_rgb;
        logic                   exp_active;
        logic [3:0]             exp_id;
        logic                   exp_rd;
    } vector_t;

    logic                   clk_sys = 1'b0;
    logic                   reset;
    logic                   plus_mode;
    logic                   crtc_clken;
    logic [ASIC_RAM_AW-1:0] crtc_ma;
    logic [4:0]             crtc_ra;
    logic                   crtc_de;
    logic [15:0]            cpu_addr;
    logic [7:0]             cpu_data;
    logic                   cpu_wr;
    logic [1:0]             r_in;
    logic [1:0]             g_in;
    logic [1:0]             b_in;
    logic [3:0]             r_out;
    logic [3:0]             g_out;
    logic [3:0]             b_out;
    logic                   sprite_active_out;
    logic [3:0]             sprite_id_out;
    logic [ASIC_RAM_AW-1:0] asic_ram_addr;
    logic                   asic_ram_rd;
    logic [7:0]             asic_ram_q;

    logic [7:0] asic_ram [0:(1<<ASIC_RAM_AW)-1];
    vector_t    vectors[$];
    // Vector index per pixel in flight, -1 for cycles without a check
    int         pending[$];
    int         check_count = 0;
    int         error_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 100;
    logic       load_ok;

    always #HALF_PERIOD clk_sys = ~clk_sys;

    // ASIC RAM model answers in the same cycle
    assign asic_ram_q = asic_ram[asic_ram_addr];

    gx4000_video gx4000_video_inst (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .plus_mode         (plus_mode),
        .crtc_clken        (crtc_clken),
        .crtc_ma           (crtc_ma),
        .crtc_ra           (crtc_ra),
        .crtc_de           (crtc_de),
        .cpu_addr          (cpu_addr),
        .cpu_data          (cpu_data),
        .cpu_wr            (cpu_wr),
        .r_in              (r_in),
        .g_in              (g_in),
        .b_in              (b_in),
        .r_out             (r_out),
        .g_out             (g_out),
        .b_out             (b_out),
        .sprite_active_out (sprite_active_out),
        .sprite_id_out     (sprite_id_out),
        .asic_ram_addr     (asic_ram_addr),
        .asic_ram_rd       (asic_ram_rd),
        .asic_ram_q        (asic_ram_q)
    );

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // RAM address the fetch should present for a pixel
    function automatic logic [ASIC_RAM_AW-1:0] expected_ram_addr(input vector_t v);
        logic [ASIC_RAM_AW-1:0] addr;
        if (!v.exp_rd) begin
            addr = v.ma;
        end else if (v.exp_active) begin
            // Sprite page at 0x1000, sixteen rows per sprite
            addr = ASIC_RAM_AW'(32'h1000 + 32'd16 * 32'(v.exp_id) + 32'(v.ra[3:0]));
        end else begin
            addr = ASIC_RAM_AW'(32'd4 * 32'(v.ra[2:0]) + 32'(v.ma[1:0]));
        end
        return addr;
    endfunction

    // Background content, overwritten by M lines
    task automatic fill_ram();
        for (int i = 0; i < (1 << ASIC_RAM_AW); i++) begin
            asic_ram[ASIC_RAM_AW'(i)] = 8'(i) ^ 8'(i >> 8);
        end
    endtask

    task automatic read_vectors(output logic ok);
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [8*256-1:0] rest;
        logic [31:0]      fld [12];
        vector_t          v;
        ok = 1'b1;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open vector file %s", VECTOR_FILE);
            ok = 1'b0;
        end
        while (ok && !$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                v = '0;
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "M": begin
                        code = $fscanf(fd, "%h %h", fld[0], fld[1]);
                        ok = (code == 2);
                        asic_ram[fld[0][ASIC_RAM_AW-1:0]] = fld[1][7:0];
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
                        ok = (code == 3);
                        v.is_write = 1'b1;
                        v.addr = fld[0][15:0];
                        v.data = fld[1][7:0];
                        v.plus = fld[2][0];
                        vectors.push_back(v);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                       fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                       fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
                        ok = (code == 12);
                        v.ma = fld[0][ASIC_RAM_AW-1:0];
                        v.ra = fld[1][4:0];
                        v.de = fld[2][0];
                        v.ga.r = fld[3][1:0];
                        v.ga.g = fld[4][1:0];
                        v.ga.b = fld[5][1:0];
                        v.exp_rgb.r = fld[6][3:0];
                        v.exp_rgb.g = fld[7][3:0];
                        v.exp_rgb.b = fld[8][3:0];
                        v.exp_active = fld[9][0];
                        v.exp_id = fld[10][3:0];
                        v.exp_rd = fld[11][0];
                        vectors.push_back(v);
                    end
                    default: begin
                        $display("Unknown line kind 0x%02h in vector file", tag);
                        ok = 1'b0;
                    end
                endcase
                if (!ok) begin
                    $display("Vector file could not be read past line kind 0x%02h", tag);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (ok && (vectors.size() == 0)) begin
            $display("Vector file holds no writes or pixels");
            ok = 1'b0;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        check_value(32'({r_out, g_out, b_out}), 32'h0, "rgb after reset");
        check_value(32'({sprite_active_out, sprite_id_out}), 32'h0, "sprite after reset");
    endtask

    // Output of a pixel two clocks after it was driven
    task automatic check_pixel(input int idx);
        vector_t v;
        v = vectors[idx];
        check_value(32'(r_out), 32'(v.exp_rgb.r), $sformatf("vector %0d r_out", idx));
        check_value(32'(g_out), 32'(v.exp_rgb.g), $sformatf("vector %0d g_out", idx));
        check_value(32'(b_out), 32'(v.exp_rgb.b), $sformatf("vector %0d b_out", idx));
        check_value(32'(sprite_active_out), 32'(v.exp_active),
                    $sformatf("vector %0d sprite_active_out", idx));
        check_value(32'(sprite_id_out), 32'(v.exp_id),
                    $sformatf("vector %0d sprite_id_out", idx));
    endtask

    // One clock, idx below zero drives an idle blanked cycle
    task automatic run_cycle(input int idx);
        int      done_idx;
        logic    is_pixel;
        vector_t v;
        @(negedge clk_sys);
        if (pending.size() == 2) begin
            done_idx = pending.pop_front();
            if (done_idx >= 0) begin
                check_pixel(done_idx);
            end
        end
        v = '0;
        is_pixel = 1'b0;
        if (idx >= 0) begin
            v = vectors[idx];
            is_pixel = !v.is_write;
        end
        cpu_wr   = (idx >= 0) && v.is_write;
        cpu_addr = v.addr;
        cpu_data = v.data;
        if (cpu_wr) begin
            plus_mode = v.plus;
        end
        // Write cycles present a blanked pixel
        crtc_ma = v.ma;
        crtc_ra = v.ra;
        crtc_de = v.de;
        r_in    = v.ga.r;
        g_in    = v.ga.g;
        b_in    = v.ga.b;
        if (is_pixel) begin
            pending.push_back(idx);
            #(HALF_PERIOD / 2);
            check_value(32'(asic_ram_rd), 32'(v.exp_rd),
                        $sformatf("vector %0d asic_ram_rd", idx));
            check_value(32'(asic_ram_addr), 32'(expected_ram_addr(v)),
                        $sformatf("vector %0d asic_ram_addr", idx));
        end else begin
            pending.push_back(-1);
        end
    endtask

    initial begin
        reset      = 1'b1;
        plus_mode  = 1'b0;
        crtc_clken = 1'b1;
        crtc_ma    = '0;
        crtc_ra    = '0;
        crtc_de    = 1'b0;
        cpu_addr   = '0;
        cpu_data   = '0;
        cpu_wr     = 1'b0;
        r_in       = '0;
        g_in       = '0;
        b_in       = '0;
        fill_ram();
        read_vectors(load_ok);
        cycle_limit = 4 * vectors.size() + 100;
        if (load_ok) begin
            apply_reset();
            for (int i = 0; i < vectors.size(); i++) begin
                run_cycle(i);
            end
            // Flush the two pixels still in the pipeline
            run_cycle(-1);
            run_cycle(-1);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (load_ok && (error_count == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/golden_vectors_video.txt ====
# M addr data | W addr data plus_mode | P ma ra de r g b exp_r exp_g exp_b exp_act exp_id exp_rd
# All hex; P outputs appear two clocks after the line is driven, exp_rd in the same cycle
# Palette entries, byte is xxBBGGRR
M 0005 1b
M 000a 24
M 000f 3f
M 0010 c6
M 001c 39
# Sprite page entries
M 1013 2d
M 1035 12
# Gate Array pass-through after reset
P 0001 01 1 1 2 3 1 2 3 0 0 0
P 0002 02 0 3 3 3 0 0 0 0 0 0
P 0003 03 1 2 0 1 2 0 1 0 0 0
# Palette mode
W bc00 01 1
W bc04 02 1
P 0125 01 1 2 2 2 3 2 1 0 0 1
P 0202 02 1 1 1 1 0 1 2 0 0 1
P 0203 03 0 3 0 3 0 0 0 0 0 0
P 1a63 0b 1 0 1 0 3 3 3 0 0 1
# Average with the previous displayed pixel
W bc02 01 1
P 0100 04 1 3 3 0 1 1 0 0 0 1
P 0204 07 1 1 0 2 2 2 1 0 0 1
P 0000 00 0 3 3 3 0 0 0 0 0 0
P 0001 01 1 0 0 3 2 1 1 0 0 1
# Sprite priority
W bc04 62 1
P 3c40 03 1 2 2 2 1 3 2 1 1 1
P 0125 01 1 3 0 1 3 0 1 0 0 1
P 3cc0 15 1 0 0 0 2 0 1 1 3 1
P 3d40 00 0 1 1 1 0 0 0 0 0 0
# Half blend
W bc04 82 1
P 0202 02 1 3 1 2 1 1 2 0 0 1
P 0100 04 1 1 3 3 1 2 1 0 0 1
P 1a63 0b 1 3 3 3 3 3 3 0 0 1
# Opcode with plus_mode low, odd address, unknown opcode, config back to zero
W bc04 02 0
P 0125 01 1 1 2 3 1 2 3 0 0 0
W bc05 02 1
P 0202 02 1 2 1 0 2 1 0 0 0 0
W bc04 55 1
P 0001 01 1 3 2 1 3 2 1 0 0 0
W bc04 02 1
W bc00 00 1
P 0100 04 1 0 3 1 0 3 1 0 0 0

// ==== verilog.f ====
logic/gx_video_pkg.sv
logic/gx_regs_pkg.sv
logic/plus_mode_regs.sv
logic/sprite_detect.sv
logic/palette_fetch.sv
logic/colour_mixer.sv
logic/gx4000_video.sv
verification/tb_gx4000_video.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_gx4000_video
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Test OK

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
